/* hdl/core_pkg.sv */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_LHU   = 6'h25;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_WORD, MEM_HALF, MEM_BYTE
    } mem_size_e;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
        logic [XLEN-1:0]       imm;
        logic [4:0]            shamt;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_e             mem_size;
        logic                  load_signed;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_e             mem_size;
        logic                  load_signed;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      wstrb;
    } dbus_req_t;

endpackage

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    output logic [XLEN-1:0]       rs_data,
    output logic [XLEN-1:0]       rt_data,
    input  wb_t                   wb
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    assign wr_en = wb.valid && wb.reg_write;

    // Write-through so decode sees the value retiring this cycle
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (wb.dest == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    output logic            ibus_req_valid,
    input  logic            ibus_req_ready,
    output ibus_req_t       ibus_req,
    input  logic            ibus_resp_valid,
    input  logic [XLEN-1:0] ibus_resp_rdata,
    output logic            fetch_valid,
    input  logic            fetch_ready,
    output fetch_pkt_t      fetch
);

    logic [XLEN-1:0] pc;
    logic            outstanding;
    logic            buf_valid;
    logic            req_fire;
    logic            resp_fire;
    logic            handoff;

    assign req_fire  = ibus_req_valid && ibus_req_ready;
    assign resp_fire = ibus_resp_valid && outstanding;
    assign handoff   = buf_valid && fetch_ready && !stall;

    // PC only moves on acceptance, so it is stable while valid is high
    assign ibus_req.addr = pc;
    assign fetch_valid   = buf_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= RESET_PC;
            ibus_req_valid <= 1'b0;
            outstanding    <= 1'b0;
        end else begin
            if (req_fire) begin
                pc             <= pc + 32'd4;
                ibus_req_valid <= 1'b0;
                outstanding    <= 1'b1;
            end else if (!ibus_req_valid && !outstanding && (!buf_valid || handoff)) begin
                // Buffer is or becomes empty, so the next response has room
                ibus_req_valid <= 1'b1;
            end
            if (resp_fire) begin
                outstanding <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (resp_fire) begin
            buf_valid <= 1'b1;
        end else if (handoff) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            fetch.instr <= ibus_resp_rdata;
            // PC has already stepped past the returned instruction
            fetch.pc    <= pc - 32'd4;
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  fetch_valid,
    output logic                  fetch_ready,
    input  fetch_pkt_t            fetch,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [XLEN-1:0]       rs_data,
    input  logic [XLEN-1:0]       rt_data,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_load,
    output id_ex_t                id_ex
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd;
    logic                  uses_rt;
    logic                  hazard;
    id_ex_t                dec;

    assign opcode  = fetch.instr[31:26];
    assign funct   = fetch.instr[5:0];
    assign rs_addr = fetch.instr[25:21];
    assign rt_addr = fetch.instr[20:16];
    assign rd      = fetch.instr[15:11];

    // Only R-type and stores read rt
    assign uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SB) ||
                     (opcode == OP_SH) || (opcode == OP_SW);

    // Load in EX feeding this instruction
    assign hazard = fetch_valid && ex_load &&
                    ((ex_dest == rs_addr) || (uses_rt && (ex_dest == rt_addr)));

    assign fetch_ready = !stall && !hazard;

    always_comb begin
        dec         = '0;
        dec.valid   = 1'b1;
        dec.rs      = rs_addr;
        dec.rt      = rt_addr;
        dec.dest    = rt_addr;
        dec.rs_val  = rs_data;
        dec.rt_val  = rt_data;
        dec.imm     = {{16{fetch.instr[15]}}, fetch.instr[15:0]};
        dec.shamt   = fetch.instr[10:6];
        dec.use_imm = 1'b1;
        dec.alu_op  = ALU_ADD;

        // Access size follows the low opcode bits for loads and stores
        case (opcode[1:0])
            2'b00:   dec.mem_size = MEM_BYTE;
            2'b01:   dec.mem_size = MEM_HALF;
            default: dec.mem_size = MEM_WORD;
        endcase

        case (opcode)
            OP_RTYPE: begin
                dec.dest      = rd;
                dec.use_imm   = 1'b0;
                dec.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: dec.reg_write = 1'b1;
            OP_SLTI: begin
                dec.alu_op    = ALU_SLT;
                dec.reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec.imm       = {16'h0000, fetch.instr[15:0]};
                dec.alu_op    = (opcode == OP_ANDI) ? ALU_AND :
                                (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
                dec.reg_write = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op    = ALU_LUI;
                dec.reg_write = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                dec.mem_read    = 1'b1;
                dec.reg_write   = 1'b1;
                // LBU and LHU have opcode bit 2 set
                dec.load_signed = !opcode[2];
            end
            OP_SB, OP_SH, OP_SW: dec.mem_write = 1'b1;
            default: ;
        endcase

        // Writes to register zero are dropped
        if (dec.dest == '0) begin
            dec.reg_write = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= (fetch_valid && fetch_ready) ? dec : '0;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  id_ex_t                id_ex,
    input  wb_t                   wb,
    output logic [REG_ADDR_W-1:0] ex_dest,
    output logic                  ex_load,
    output ex_mem_t               ex_mem
);

    logic [XLEN-1:0] rs_fwd;
    logic [XLEN-1:0] rt_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    assign ex_dest = id_ex.dest;
    assign ex_load = id_ex.valid && id_ex.mem_read;

    // Youngest producer first, register file value last
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] idx,
                                                input logic [XLEN-1:0]       rf_val);
        if (ex_mem.valid && ex_mem.reg_write && (ex_mem.dest == idx)) begin
            return ex_mem.alu_result;
        end
        if (wb.valid && wb.reg_write && (wb.dest == idx)) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_fwd = forward(id_ex.rs, id_ex.rs_val);
        rt_fwd = forward(id_ex.rt, id_ex.rt_val);
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = rs_fwd + op_b;
            ALU_SUB: alu_result = rs_fwd - op_b;
            ALU_AND: alu_result = rs_fwd & op_b;
            ALU_OR:  alu_result = rs_fwd | op_b;
            ALU_XOR: alu_result = rs_fwd ^ op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(rs_fwd) < $signed(op_b)};
            // Shifts take rt and the shamt field
            ALU_SLL: alu_result = rt_fwd << id_ex.shamt;
            ALU_SRL: alu_result = rt_fwd >> id_ex.shamt;
            ALU_LUI: alu_result = {id_ex.imm[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem.valid       <= id_ex.valid;
            ex_mem.alu_result  <= alu_result;
            ex_mem.store_data  <= rt_fwd;
            ex_mem.dest        <= id_ex.dest;
            ex_mem.reg_write   <= id_ex.valid && id_ex.reg_write;
            ex_mem.mem_read    <= id_ex.valid && id_ex.mem_read;
            ex_mem.mem_write   <= id_ex.valid && id_ex.mem_write;
            ex_mem.mem_size    <= id_ex.mem_size;
            ex_mem.load_signed <= id_ex.load_signed;
        end
    end

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_mem_t         ex_mem,
    output logic            dbus_req_valid,
    input  logic            dbus_req_ready,
    output dbus_req_t       dbus_req,
    input  logic            dbus_resp_valid,
    input  logic [XLEN-1:0] dbus_resp_rdata,
    output logic            mem_busy,
    output wb_t             wb
);

    logic            mem_op;
    logic            waiting;
    logic            resp_fire;
    logic [1:0]      lane;
    logic [3:0]      wstrb;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata_sel;
    logic [XLEN-1:0] load_data;

    assign lane      = ex_mem.alu_result[1:0];
    assign mem_op    = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
    assign resp_fire = dbus_resp_valid && waiting;

    // Pipeline holds from entry of a memory op up to its response
    assign mem_busy = mem_op && !resp_fire;

    // Store lane placement
    always_comb begin
        case (ex_mem.mem_size)
            MEM_BYTE: begin
                wstrb = 4'b0001 << lane;
                wdata = {24'h000000, ex_mem.store_data[7:0]} << {lane, 3'b000};
            end
            MEM_HALF: begin
                wstrb = lane[1] ? 4'b1100 : 4'b0011;
                wdata = lane[1] ? {ex_mem.store_data[15:0], 16'h0000} :
                                  {16'h0000, ex_mem.store_data[15:0]};
            end
            default: begin
                wstrb = 4'b1111;
                wdata = ex_mem.store_data;
            end
        endcase
    end

    // EX/MEM is frozen while busy, so the payload stays stable
    assign dbus_req.addr  = (ex_mem.mem_size == MEM_WORD) ?
                            {ex_mem.alu_result[XLEN-1:2], 2'b00} : ex_mem.alu_result;
    assign dbus_req.wdata = ex_mem.mem_write ? wdata : '0;
    assign dbus_req.wstrb = ex_mem.mem_write ? wstrb : 4'b0000;

    // Load lane extraction and extension
    always_comb begin
        rdata_sel = dbus_resp_rdata;
        case (ex_mem.mem_size)
            MEM_BYTE: begin
                rdata_sel = dbus_resp_rdata >> {lane, 3'b000};
                load_data = {{24{ex_mem.load_signed & rdata_sel[7]}}, rdata_sel[7:0]};
            end
            MEM_HALF: begin
                rdata_sel = dbus_resp_rdata >> {lane[1], 4'b0000};
                load_data = {{16{ex_mem.load_signed & rdata_sel[15]}}, rdata_sel[15:0]};
            end
            default: load_data = rdata_sel;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbus_req_valid <= 1'b0;
            waiting        <= 1'b0;
        end else begin
            if (dbus_req_valid && dbus_req_ready) begin
                dbus_req_valid <= 1'b0;
                waiting        <= 1'b1;
            end else if (mem_op && !dbus_req_valid && !waiting) begin
                dbus_req_valid <= 1'b1;
            end
            if (resp_fire) begin
                waiting <= 1'b0;
            end
        end
    end

    // MEM/WB holds while busy so forwarding from it stays valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!mem_busy) begin
            wb.valid     <= ex_mem.valid;
            wb.reg_write <= ex_mem.valid && ex_mem.reg_write;
            wb.dest      <= ex_mem.dest;
            wb.data      <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,

    output logic            ibus_req_valid,
    input  logic            ibus_req_ready,
    output ibus_req_t       ibus_req,
    input  logic            ibus_resp_valid,
    input  logic [XLEN-1:0] ibus_resp_rdata,

    output logic            dbus_req_valid,
    input  logic            dbus_req_ready,
    output dbus_req_t       dbus_req,
    input  logic            dbus_resp_valid,
    input  logic [XLEN-1:0] dbus_resp_rdata
);

    logic                  fetch_valid;
    logic                  fetch_ready;
    fetch_pkt_t            fetch;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic                  ex_load;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    wb_t                   wb;
    logic                  mem_busy;

    fetch_unit fetch_unit_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (mem_busy),
        .ibus_req_valid  (ibus_req_valid),
        .ibus_req_ready  (ibus_req_ready),
        .ibus_req        (ibus_req),
        .ibus_resp_valid (ibus_resp_valid),
        .ibus_resp_rdata (ibus_resp_rdata),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch           (fetch)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (mem_busy),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .ex_dest     (ex_dest),
        .ex_load     (ex_load),
        .id_ex       (id_ex)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    execute_stage execute_stage_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (mem_busy),
        .id_ex   (id_ex),
        .wb      (wb),
        .ex_dest (ex_dest),
        .ex_load (ex_load),
        .ex_mem  (ex_mem)
    );

    mem_stage mem_stage_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_mem          (ex_mem),
        .dbus_req_valid  (dbus_req_valid),
        .dbus_req_ready  (dbus_req_ready),
        .dbus_req        (dbus_req),
        .dbus_resp_valid (dbus_resp_valid),
        .dbus_resp_rdata (dbus_resp_rdata),
        .mem_busy        (mem_busy),
        .wb              (wb)
    );

endmodule

/* verification/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Sequential reference run of prog over a copy of init_mem
// Fills exp_addr, exp_wdata and exp_wstrb in program order
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] res;
    logic [31:0] word;
    logic [31:0] wd;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  dest;
    logic [7:0]  addr;
    logic [3:0]  strb;
    logic        wr;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mem[i] = init_mem[i];
    end
    for (int pc = 0; pc < NUM_INSTR; pc++) begin
        ins   = prog[pc];
        op    = ins[31:26];
        fn    = ins[5:0];
        a     = regs[ins[25:21]];
        b     = regs[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0000, ins[15:0]};
        addr  = ins[7:0];
        word  = mem[addr[7:2]];
        dest  = ins[20:16];
        wr    = 1'b1;
        res   = '0;
        case (op)
            OP_RTYPE: begin
                dest = ins[15:11];
                case (fn)
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << ins[10:6];
                    FN_SRL:  res = b >> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + imm_s;
            OP_SLTI:  res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & imm_z;
            OP_ORI:   res = a | imm_z;
            OP_XORI:  res = a ^ imm_z;
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                exp_addr.push_back((op == OP_LW) ? {24'h0, addr[7:2], 2'b00} : {24'h0, addr});
                exp_wdata.push_back('0);
                exp_wstrb.push_back(4'b0000);
                case (op)
                    OP_LB:  res = {{24{word[8*addr[1:0]+7]}}, word[8*addr[1:0] +: 8]};
                    OP_LBU: res = {24'h0, word[8*addr[1:0] +: 8]};
                    OP_LH:  res = {{16{word[16*addr[1]+15]}}, word[16*addr[1] +: 16]};
                    OP_LHU: res = {16'h0, word[16*addr[1] +: 16]};
                    default: res = word;
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                wr = 1'b0;
                if (op == OP_SB) begin
                    strb = 4'b0001 << addr[1:0];
                    wd   = {24'h0, b[7:0]} << (8 * addr[1:0]);
                end else if (op == OP_SH) begin
                    strb = addr[1] ? 4'b1100 : 4'b0011;
                    wd   = addr[1] ? {b[15:0], 16'h0} : {16'h0, b[15:0]};
                end else begin
                    strb = 4'b1111;
                    wd   = b;
                end
                exp_addr.push_back((op == OP_SW) ? {24'h0, addr[7:2], 2'b00} : {24'h0, addr});
                exp_wdata.push_back(wd);
                exp_wstrb.push_back(strb);
                for (int k = 0; k < 4; k++) begin
                    if (strb[k]) begin
                        mem[addr[7:2]][8*k +: 8] = wd[8*k +: 8];
                    end
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            regs[dest] = res;
        end
    end
endtask

`endif

/* verification/tb_cpu_core.sv */
`timescale 1ns/1ns

module tb_cpu_core import core_pkg::*; ();

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 8;
    localparam int NUM_INSTR        = 200;
    localparam int CYCLES_PER_INSTR = 40;

    logic        clk;
    logic        rst_n;
    logic        ibus_req_valid;
    logic        ibus_req_ready;
    ibus_req_t   ibus_req;
    logic        ibus_resp_valid;
    logic [31:0] ibus_resp_rdata;
    logic        dbus_req_valid;
    logic        dbus_req_ready;
    dbus_req_t   dbus_req;
    logic        dbus_resp_valid;
    logic [31:0] dbus_resp_rdata;

    logic [31:0] seed;
    logic [31:0] prog [256];
    logic [31:0] init_mem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_wdata [$];
    logic [3:0]  exp_wstrb [$];
    int          seen;
    int          errors;
    logic        first_ireq_seen;

    // Responder state for one outstanding request per bus
    logic        i_pending;
    int          i_wait;
    logic [31:0] i_data;
    logic        d_pending;
    int          d_wait;
    logic [31:0] d_data;

    `include "isa_model.svh"

    cpu_core cpu_core_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .ibus_req_valid  (ibus_req_valid),
        .ibus_req_ready  (ibus_req_ready),
        .ibus_req        (ibus_req),
        .ibus_resp_valid (ibus_resp_valid),
        .ibus_resp_rdata (ibus_resp_rdata),
        .dbus_req_valid  (dbus_req_valid),
        .dbus_req_ready  (dbus_req_ready),
        .dbus_req        (dbus_req),
        .dbus_resp_valid (dbus_resp_valid),
        .dbus_resp_rdata (dbus_resp_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            fail_run($sformatf("ERROR at %0t ns: %s got %h expected %h",
                               $time, name, got, expected));
        end
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [7:0]  addr;
        logic [5:0]  op;
        logic [5:0]  fn;
        int unsigned kind;
        kind = rand_below(10);
        rs   = 5'(rand_below(8));
        rt   = 5'(rand_below(8));
        rd   = 5'(rand_below(8));
        addr = 8'(rand_below(256));
        if (kind < 3) begin
            case (rand_below(8))
                0: fn = FN_ADDU;
                1: fn = FN_SUBU;
                2: fn = FN_AND;
                3: fn = FN_OR;
                4: fn = FN_XOR;
                5: fn = FN_SLT;
                6: fn = FN_SLL;
                default: fn = FN_SRL;
            endcase
            if (fn == FN_SLL || fn == FN_SRL) begin
                return {OP_RTYPE, 5'd0, rt, rd, 5'(rand_below(32)), fn};
            end
            return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
        end else if (kind < 5) begin
            case (rand_below(6))
                0: op = OP_ADDIU;
                1: op = OP_SLTI;
                2: op = OP_ANDI;
                3: op = OP_ORI;
                4: op = OP_XORI;
                default: op = OP_LUI;
            endcase
            return {op, rs, rt, 16'(rand_below(65536))};
        end else if (kind < 7) begin
            case (rand_below(5))
                0: op = OP_LB;
                1: op = OP_LBU;
                2: op = OP_LH;
                3: op = OP_LHU;
                default: op = OP_LW;
            endcase
        end else begin
            case (rand_below(3))
                0: op = OP_SB;
                1: op = OP_SH;
                default: op = OP_SW;
            endcase
        end
        // Natural alignment from the size bits of the opcode
        if (op[1:0] == 2'b01) begin
            addr[0] = 1'b0;
        end else if (op[1:0] == 2'b11) begin
            addr[1:0] = 2'b00;
        end
        return {op, 5'd0, rt, 8'h00, addr};
    endfunction

    initial begin
        seed            = 32'hd001;
        clk             = 1'b0;
        rst_n           = 1'b0;
        ibus_req_ready  = 1'b0;
        ibus_resp_valid = 1'b0;
        ibus_resp_rdata = '0;
        dbus_req_ready  = 1'b0;
        dbus_resp_valid = 1'b0;
        dbus_resp_rdata = '0;
        seen            = 0;
        errors          = 0;
        first_ireq_seen = 1'b0;
        i_pending       = 1'b0;
        d_pending       = 1'b0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = (i < NUM_INSTR) ? random_instr() : 32'h0000_0000;
        end
        for (int i = 0; i < 64; i++) begin
            init_mem[i] = $random(seed);
            dmem[i]     = init_mem[i];
        end
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (seen == exp_addr.size());
        // Idle tail to catch any extra request
        repeat (50) @(posedge clk);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((NUM_INSTR * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD);
        fail_run($sformatf("Timeout: only %0d of %0d data-bus requests seen",
                           seen, exp_addr.size()));
    end

    // Instruction memory responder
    always @(posedge clk) begin
        if (rst_n) begin
            ibus_resp_valid <= 1'b0;
            if (i_pending) begin
                if (i_wait <= 1) begin
                    ibus_resp_valid <= 1'b1;
                    ibus_resp_rdata <= i_data;
                    i_pending = 1'b0;
                end else begin
                    i_wait--;
                end
            end
            if (ibus_req_valid && ibus_req_ready) begin
                i_pending = 1'b1;
                i_wait    = 1 + rand_below(4);
                i_data    = (ibus_req.addr[31:2] < 256) ? prog[ibus_req.addr[9:2]] : '0;
            end
            ibus_req_ready <= (rand_below(4) != 0);
        end
    end

    // Data memory responder that applies writes at acceptance
    always @(posedge clk) begin
        if (rst_n) begin
            dbus_resp_valid <= 1'b0;
            if (d_pending) begin
                if (d_wait <= 1) begin
                    dbus_resp_valid <= 1'b1;
                    dbus_resp_rdata <= d_data;
                    d_pending = 1'b0;
                end else begin
                    d_wait--;
                end
            end
            if (dbus_req_valid && dbus_req_ready) begin
                d_pending = 1'b1;
                d_wait    = 1 + rand_below(4);
                d_data    = dmem[dbus_req.addr[7:2]];
                for (int k = 0; k < 4; k++) begin
                    if (dbus_req.wstrb[k]) begin
                        dmem[dbus_req.addr[7:2]][8*k +: 8] = dbus_req.wdata[8*k +: 8];
                    end
                end
            end
            dbus_req_ready <= (rand_below(4) != 0);
        end
    end

    // Reset values, first fetch address and the data-bus request stream
    always @(posedge clk) begin
        if (!rst_n) begin
            check_value("ibus_req_valid", 32'(ibus_req_valid), 32'd0);
            check_value("dbus_req_valid", 32'(dbus_req_valid), 32'd0);
        end else begin
            if (ibus_req_valid && !first_ireq_seen) begin
                first_ireq_seen = 1'b1;
                check_value("ibus_req.addr", ibus_req.addr, 32'd0);
            end
            if (dbus_req_valid && dbus_req_ready) begin
                if (seen >= exp_addr.size()) begin
                    fail_run("Data bus issued more requests than the program contains");
                end
                check_value("dbus_req.addr", dbus_req.addr, exp_addr[seen]);
                check_value("dbus_req.wstrb", 32'(dbus_req.wstrb), 32'(exp_wstrb[seen]));
                check_value("dbus_req.wdata", dbus_req.wdata, exp_wdata[seen]);
                seen++;
            end
        end
    end

endmodule

/* files.f */
+incdir+verification
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/cpu_core.sv
verification/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_cpu_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
